// ==== list.f ====
rob_cfg_pkg.sv
rob_chan_pkg.sv
rob_slot_alloc.sv
rob_buffer.sv
rob_release.sv
rob_id_tracker.sv
rob_wrapper.sv
tb_rob_harness.sv
tb_rob_top.sv

// ==== rob_buffer.sv ====
// **********************************************************************
// Reorder buffer storage
// Flip-flop slots written out of order at the tagged index, with an
// occupied bit per slot and a read port at the head
// **********************************************************************
`timescale 1ns/1ns
`default_nettype none

module rob_buffer
  import rob_cfg_pkg::*;
  import rob_chan_pkg::*;
#(
  parameter int unsigned RobSize  = RobSizeDefault,
  parameter int unsigned IdxWidth = $clog2(RobSize)
) (
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  input  wire logic                 wr_en_i,
  input  wire logic [IdxWidth-1:0]  wr_idx_i,
  input  wire logic [DataWidth-1:0] wr_data_i,
  input  wire logic [IdWidth-1:0]   wr_id_i,
  input  wire logic                 wr_last_i,
  input  wire logic [IdxWidth-1:0]  head_idx_i,
  input  wire logic                 pop_i,
  output logic                      head_occupied_o,
  output logic [DataWidth-1:0]      head_data_o,
  output logic [IdWidth-1:0]        head_id_o,
  output logic                      head_last_o,
  output logic                      slot_free_o
);

  logic [RobSize-1:0]   occupied_q;
  logic [DataWidth-1:0] data_q [RobSize];
  logic [IdWidth-1:0]   id_q   [RobSize];
  logic                 last_q [RobSize];

  assign slot_free_o = !occupied_q[wr_idx_i];

  // Head read port
  assign head_occupied_o = occupied_q[head_idx_i];
  assign head_data_o     = data_q[head_idx_i];
  assign head_id_o       = id_q[head_idx_i];
  assign head_last_o     = last_q[head_idx_i];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      occupied_q <= '0;
    end else begin
      // Pop and write never target the same slot
      if (pop_i) begin
        occupied_q[head_idx_i] <= 1'b0;
      end
      if (wr_en_i) begin
        occupied_q[wr_idx_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      data_q[wr_idx_i] <= wr_data_i;
      id_q[wr_idx_i]   <= wr_id_i;
      last_q[wr_idx_i] <= wr_last_i;
    end
  end

  // A beat must land in a slot reserved for it and not yet filled
  a_no_overwrite: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) wr_en_i |-> !occupied_q[wr_idx_i]
  ) else $error("write to occupied slot %0d", wr_idx_i);

endmodule

`default_nettype wire

// ==== rob_cfg_pkg.sv ====
// **********************************************************************
// Reorder buffer configuration
// Selects the buffer kind and holds the default sizing values
// **********************************************************************
`default_nettype none

package rob_cfg_pkg;

  // Which response path the wrapper builds
  typedef enum logic [1:0] {
    NormalRoB = 2'd0,
    NoRoB     = 2'd1
  } rob_type_e;

  // Slots in the circular response buffer
  localparam int unsigned RobSizeDefault = 32'd16;

  // Outstanding transactions allowed per ID without reordering
  localparam int unsigned MaxTxnsPerIdDefault = 32'd4;

endpackage

`default_nettype wire

// ==== rob_chan_pkg.sv ====
// **********************************************************************
// Request and response channel fields
// Widths of the ID, destination, burst length and data fields
// **********************************************************************
`default_nettype none

package rob_chan_pkg;

  // Transaction ID
  localparam int unsigned IdWidth = 32'd4;

  // Destination endpoint in the network
  localparam int unsigned DestWidth = 32'd2;

  // Burst length, len means len+1 beats
  localparam int unsigned LenWidth = 32'd3;

  // Response payload
  localparam int unsigned DataWidth = 32'd32;

endpackage

`default_nettype wire

// ==== rob_id_tracker.sv ====
// **********************************************************************
// Per-ID transaction tracker
// Lets a request through only if earlier ones with its ID went to the
// same destination and the ID is below its outstanding limit
// **********************************************************************
`timescale 1ns/1ns
`default_nettype none

module rob_id_tracker
  import rob_cfg_pkg::*;
  import rob_chan_pkg::*;
#(
  parameter int unsigned MaxTxnsPerId = MaxTxnsPerIdDefault
) (
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  input  wire logic                 ax_valid_i,
  input  wire logic [IdWidth-1:0]   ax_id_i,
  input  wire logic [DestWidth-1:0] ax_dest_i,
  input  wire logic                 ax_ready_i,
  input  wire logic                 rsp_valid_i,
  input  wire logic [IdWidth-1:0]   rsp_id_i,
  input  wire logic                 rsp_last_i,
  input  wire logic                 rsp_ready_i,
  output logic                      ax_valid_o,
  output logic                      ax_ready_o
);

  localparam int unsigned NumIds   = 2 ** IdWidth;
  localparam int unsigned CntWidth = $clog2(MaxTxnsPerId) + 1;

  logic [CntWidth-1:0]  cnt_q  [NumIds];
  logic [DestWidth-1:0] dest_q [NumIds];
  logic                 in_flight;
  logic                 same_dest;
  logic                 cnt_full;
  logic                 push;
  logic                 pop;

  assign in_flight = cnt_q[ax_id_i] != '0;
  assign same_dest = dest_q[ax_id_i] == ax_dest_i;
  assign cnt_full  = cnt_q[ax_id_i] == CntWidth'(MaxTxnsPerId);

  assign ax_valid_o = ax_valid_i && (!in_flight || same_dest) && !cnt_full;
  assign ax_ready_o = ax_valid_o && ax_ready_i;

  // Count on handshakes only; a burst retires with its last beat
  assign push = ax_ready_o;
  assign pop  = rsp_valid_i && rsp_ready_i && rsp_last_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < NumIds; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NumIds; i++) begin
        // Same-ID push and pop cancel out
        if (push && ax_id_i == IdWidth'(i) && !(pop && rsp_id_i == IdWidth'(i))) begin
          cnt_q[i] <= cnt_q[i] + CntWidth'(1);
        end else if (pop && rsp_id_i == IdWidth'(i) && !(push && ax_id_i == IdWidth'(i))) begin
          cnt_q[i] <= cnt_q[i] - CntWidth'(1);
        end
      end
    end
  end

  // Destination only matters while the counter is nonzero
  always_ff @(posedge clk_i) begin
    if (push) begin
      dest_q[ax_id_i] <= ax_dest_i;
    end
  end

  // Every last beat must belong to a request that went out
  a_no_underflow: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) pop |-> cnt_q[rsp_id_i] != '0
  ) else $error("last beat for ID %0d with nothing outstanding", rsp_id_i);

endmodule

`default_nettype wire

// ==== rob_release.sv ====
// **********************************************************************
// Reorder buffer release
// Walks the head pointer and hands stored beats out in request order
// **********************************************************************
`timescale 1ns/1ns
`default_nettype none

module rob_release
  import rob_cfg_pkg::*;
  import rob_chan_pkg::*;
#(
  parameter int unsigned RobSize  = RobSizeDefault,
  parameter int unsigned IdxWidth = $clog2(RobSize)
) (
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  input  wire logic                 head_occupied_i,
  input  wire logic [DataWidth-1:0] head_data_i,
  input  wire logic [IdWidth-1:0]   head_id_i,
  input  wire logic                 head_last_i,
  input  wire logic                 rsp_ready_i,
  output logic [IdxWidth-1:0]       head_idx_o,
  output logic                      pop_o,
  output logic                      free_o,
  output logic                      rsp_valid_o,
  output logic [DataWidth-1:0]      rsp_data_o,
  output logic [IdWidth-1:0]        rsp_id_o,
  output logic                      rsp_last_o
);

  logic [IdxWidth-1:0] head_q;

  // Head beat goes out as soon as its slot is filled
  assign rsp_valid_o = head_occupied_i;
  assign rsp_data_o  = head_data_i;
  assign rsp_id_o    = head_id_i;
  assign rsp_last_o  = head_last_i;

  assign pop_o      = rsp_valid_o && rsp_ready_i;
  assign free_o     = pop_o;
  assign head_idx_o = head_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_q <= '0;
    end else if (pop_o) begin
      if (head_q == IdxWidth'(RobSize - 1)) begin
        head_q <= '0;
      end else begin
        head_q <= head_q + IdxWidth'(1);
      end
    end
  end

  // Stalled beat stays put until the master takes it
  a_hold_stalled: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_data_o) && $stable(rsp_id_o)
  ) else $error("stalled response changed at head %0d", head_q);

endmodule

`default_nettype wire

// ==== rob_slot_alloc.sv ====
// **********************************************************************
// Reorder buffer slot allocator
// Reserves len+1 consecutive slots per request and tags it with the
// base slot index; released slots return through free_i
// **********************************************************************
`timescale 1ns/1ns
`default_nettype none

module rob_slot_alloc
  import rob_cfg_pkg::*;
  import rob_chan_pkg::*;
#(
  parameter int unsigned RobSize  = RobSizeDefault,
  parameter int unsigned IdxWidth = $clog2(RobSize)
) (
  input  wire logic                clk_i,
  input  wire logic                arst_n_i,
  input  wire logic                ax_valid_i,
  input  wire logic [LenWidth-1:0] ax_len_i,
  input  wire logic                ax_ready_i,
  input  wire logic                free_i,
  output logic                     ax_valid_o,
  output logic                     ax_ready_o,
  output logic [IdxWidth-1:0]      ax_rob_idx_o
);

  // Wide enough for the free count and for tail plus burst
  localparam int unsigned CntWidth = $clog2(RobSize + 1) + LenWidth;

  logic [IdxWidth-1:0] tail_q;
  logic [CntWidth-1:0] free_q;
  logic [CntWidth-1:0] free_d;
  logic [CntWidth-1:0] beats;
  logic [CntWidth-1:0] tail_sum;

  assign beats = CntWidth'(ax_len_i) + CntWidth'(1);

  // Only let the request out when the whole burst fits
  assign ax_valid_o   = ax_valid_i && (free_q >= beats);
  assign ax_ready_o   = ax_valid_o && ax_ready_i;
  assign ax_rob_idx_o = tail_q;

  // Wrap the tail around the end of the buffer
  always_comb begin
    tail_sum = CntWidth'(tail_q) + beats;
    if (tail_sum >= CntWidth'(RobSize)) begin
      tail_sum = tail_sum - CntWidth'(RobSize);
    end
  end

  always_comb begin
    free_d = free_q;
    if (ax_ready_o) begin
      free_d = free_d - beats;
    end
    // One slot back per released beat
    if (free_i) begin
      free_d = free_d + CntWidth'(1);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tail_q <= '0;
      free_q <= CntWidth'(RobSize);
    end else begin
      free_q <= free_d;
      if (ax_ready_o) begin
        tail_q <= IdxWidth'(tail_sum);
      end
    end
  end

  // Released beats can never outnumber reserved ones
  a_free_bounded: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) free_q <= CntWidth'(RobSize)
  ) else $error("free slot count %0d above buffer size", free_q);

endmodule

`default_nettype wire

// ==== rob_wrapper.sv ====
// **********************************************************************
// Response reorder wrapper
// Builds either the slot-based reorder buffer or the per-ID tracker
// that forwards responses unchanged
// **********************************************************************
`timescale 1ns/1ns
`default_nettype none

module rob_wrapper
  import rob_cfg_pkg::*;
  import rob_chan_pkg::*;
#(
  parameter rob_type_e   RobType      = NormalRoB,
  parameter int unsigned RobSize      = RobSizeDefault,
  parameter int unsigned MaxTxnsPerId = MaxTxnsPerIdDefault,
  parameter int unsigned IdxWidth     = $clog2(RobSize)
) (
  input  wire logic                 clk_i,
  input  wire logic                 arst_n_i,
  input  wire logic                 ax_valid_i,
  output logic                      ax_ready_o,
  input  wire logic [LenWidth-1:0]  ax_len_i,
  input  wire logic [IdWidth-1:0]   ax_id_i,
  input  wire logic [DestWidth-1:0] ax_dest_i,
  output logic                      ax_valid_o,
  input  wire logic                 ax_ready_i,
  output logic                      ax_rob_req_o,
  output logic [IdxWidth-1:0]       ax_rob_idx_o,
  input  wire logic                 rsp_valid_i,
  output logic                      rsp_ready_o,
  input  wire logic [DataWidth-1:0] rsp_data_i,
  input  wire logic [IdWidth-1:0]   rsp_id_i,
  input  wire logic                 rsp_rob_req_i,
  input  wire logic [IdxWidth-1:0]  rsp_rob_idx_i,
  input  wire logic                 rsp_last_i,
  output logic                      rsp_valid_o,
  input  wire logic                 rsp_ready_i,
  output logic [DataWidth-1:0]      rsp_data_o,
  output logic [IdWidth-1:0]        rsp_id_o,
  output logic                      rsp_last_o
);

  if (RobType == NormalRoB) begin : gen_normal_rob
    logic                wr_en;
    logic                slot_free;
    logic                head_occupied;
    logic [DataWidth-1:0] head_data;
    logic [IdWidth-1:0]  head_id;
    logic                head_last;
    logic [IdxWidth-1:0] head_idx;
    logic                pop;
    logic                free;

    assign ax_rob_req_o = 1'b1;

    // Reserved slots are empty, so a tagged beat is taken at once
    assign rsp_ready_o = slot_free;
    assign wr_en       = rsp_valid_i && rsp_rob_req_i;

    rob_slot_alloc #(
      .RobSize  ( RobSize  ),
      .IdxWidth ( IdxWidth )
    ) i_slot_alloc (
      .clk_i,
      .arst_n_i,
      .ax_valid_i,
      .ax_len_i,
      .ax_ready_i,
      .free_i       ( free         ),
      .ax_valid_o,
      .ax_ready_o,
      .ax_rob_idx_o
    );

    rob_buffer #(
      .RobSize  ( RobSize  ),
      .IdxWidth ( IdxWidth )
    ) i_buffer (
      .clk_i,
      .arst_n_i,
      .wr_en_i         ( wr_en         ),
      .wr_idx_i        ( rsp_rob_idx_i ),
      .wr_data_i       ( rsp_data_i    ),
      .wr_id_i         ( rsp_id_i      ),
      .wr_last_i       ( rsp_last_i    ),
      .head_idx_i      ( head_idx      ),
      .pop_i           ( pop           ),
      .head_occupied_o ( head_occupied ),
      .head_data_o     ( head_data     ),
      .head_id_o       ( head_id       ),
      .head_last_o     ( head_last     ),
      .slot_free_o     ( slot_free     )
    );

    rob_release #(
      .RobSize  ( RobSize  ),
      .IdxWidth ( IdxWidth )
    ) i_release (
      .clk_i,
      .arst_n_i,
      .head_occupied_i ( head_occupied ),
      .head_data_i     ( head_data     ),
      .head_id_i       ( head_id       ),
      .head_last_i     ( head_last     ),
      .rsp_ready_i,
      .head_idx_o      ( head_idx      ),
      .pop_o           ( pop           ),
      .free_o          ( free          ),
      .rsp_valid_o,
      .rsp_data_o,
      .rsp_id_o,
      .rsp_last_o
    );

  end else if (RobType == NoRoB) begin : gen_no_rob
    assign ax_rob_req_o = 1'b0;
    assign ax_rob_idx_o = '0;

    // Ordering is guaranteed upstream, so responses pass straight through
    assign rsp_ready_o = rsp_ready_i;
    assign rsp_valid_o = rsp_valid_i;
    assign rsp_data_o  = rsp_data_i;
    assign rsp_id_o    = rsp_id_i;
    assign rsp_last_o  = rsp_last_i;

    rob_id_tracker #(
      .MaxTxnsPerId ( MaxTxnsPerId )
    ) i_id_tracker (
      .clk_i,
      .arst_n_i,
      .ax_valid_i,
      .ax_id_i,
      .ax_dest_i,
      .ax_ready_i,
      .rsp_valid_i,
      .rsp_id_i,
      .rsp_last_i,
      .rsp_ready_i,
      .ax_valid_o,
      .ax_ready_o
    );

  end else begin : gen_error
    $error("Unsupported RobType %0d", RobType);
  end

endmodule

`default_nettype wire

// ==== tb_rob_harness.sv ====
// **********************************************************************
// Reorder wrapper test harness
// Drives one DUT with an out-of-order responder model and checks the
// response order, back-pressure, capacity and per-ID request rules
// **********************************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_rob_harness
  import rob_cfg_pkg::*;
  import rob_chan_pkg::*;
#(
  parameter rob_type_e   RobType      = NormalRoB,
  parameter int unsigned RobSize      = RobSizeDefault,
  parameter int unsigned MaxTxnsPerId = MaxTxnsPerIdDefault
) (
  input  wire logic clk_i,
  input  wire logic arst_n_i,
  output logic      done_o,
  output int        pass_cnt_o,
  output int        fail_cnt_o
);

  localparam int unsigned IdxWidth = $clog2(RobSize);
  localparam int unsigned RunLimit = 4000;

  logic                 drv_ax_valid;
  logic [LenWidth-1:0]  drv_ax_len;
  logic [IdWidth-1:0]   drv_ax_id;
  logic [DestWidth-1:0] drv_ax_dest;
  logic                 drv_ax_ready;
  logic                 drv_rsp_valid;
  logic [DataWidth-1:0] drv_rsp_data;
  logic [IdWidth-1:0]   drv_rsp_id;
  logic [IdxWidth-1:0]  drv_rsp_idx;
  logic                 drv_rsp_last;
  logic                 drv_rsp_ready;
  logic                 dut_ax_ready;
  logic                 dut_ax_valid;
  logic                 dut_rob_req;
  logic [IdxWidth-1:0]  dut_rob_idx;
  logic                 dut_rsp_ready;
  logic                 dut_rsp_valid;
  logic [DataWidth-1:0] dut_rsp_data;
  logic [IdWidth-1:0]   dut_rsp_id;
  logic                 dut_rsp_last;

  // Beats still in the network as {data, id, idx, last}, expected output as {data, id, last}
  logic [DataWidth+IdWidth+IdxWidth:0] pend_q[$];
  logic [DataWidth+IdWidth:0]          exp_q[$];
  int    err_by_test[string];
  bit    closed[string];
  int    free_model;
  int    tail_model;
  int    issued;
  int    pick;
  bit    taken;
  string mode_name;
  string cur_test;

  rob_wrapper #(
    .RobType      ( RobType      ),
    .RobSize      ( RobSize      ),
    .MaxTxnsPerId ( MaxTxnsPerId )
  ) rob_wrapper_inst (
    .clk_i         ( clk_i                 ),
    .arst_n_i      ( arst_n_i              ),
    .ax_valid_i    ( drv_ax_valid          ),
    .ax_ready_o    ( dut_ax_ready          ),
    .ax_len_i      ( drv_ax_len            ),
    .ax_id_i       ( drv_ax_id             ),
    .ax_dest_i     ( drv_ax_dest           ),
    .ax_valid_o    ( dut_ax_valid          ),
    .ax_ready_i    ( drv_ax_ready          ),
    .ax_rob_req_o  ( dut_rob_req           ),
    .ax_rob_idx_o  ( dut_rob_idx           ),
    .rsp_valid_i   ( drv_rsp_valid         ),
    .rsp_ready_o   ( dut_rsp_ready         ),
    .rsp_data_i    ( drv_rsp_data          ),
    .rsp_id_i      ( drv_rsp_id            ),
    .rsp_rob_req_i ( RobType == NormalRoB  ),
    .rsp_rob_idx_i ( drv_rsp_idx           ),
    .rsp_last_i    ( drv_rsp_last          ),
    .rsp_valid_o   ( dut_rsp_valid         ),
    .rsp_ready_i   ( drv_rsp_ready         ),
    .rsp_data_o    ( dut_rsp_data          ),
    .rsp_id_o      ( dut_rsp_id            ),
    .rsp_last_o    ( dut_rsp_last          )
  );

  function automatic void count_error(input string tname);
    if (err_by_test.exists(tname)) begin
      err_by_test[tname]++;
    end else begin
      err_by_test[tname] = 1;
      // A test already closed as passing turns into a failure
      if (closed.exists(tname)) begin
        pass_cnt_o--;
        fail_cnt_o++;
      end
    end
  endfunction

  function automatic void flag_value(input string tname, input longint expected,
                                     input longint actual);
    $display("[ERROR] %s %s: expected %0h, actual %0h", mode_name, tname, expected, actual);
    count_error(tname);
  endfunction

  task automatic finish_test(input string tname);
    closed[tname] = 1'b1;
    if (err_by_test.exists(tname)) begin
      $display("%s %s: FAIL with %0d errors", mode_name, tname, err_by_test[tname]);
      fail_cnt_o++;
    end else begin
      $display("%s %s: pass", mode_name, tname);
      pass_cnt_o++;
    end
  endtask

  // Stalled head beat stays valid and keeps its payload
  a_hold_stalled: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    RobType == NormalRoB && dut_rsp_valid && !drv_rsp_ready |=>
      dut_rsp_valid && $stable({dut_rsp_data, dut_rsp_id, dut_rsp_last})
  ) else begin
    $display("%s %s: stalled response was dropped or changed", mode_name, cur_test);
    count_error(cur_test);
  end

  // Without reordering the response channel is a plain wire
  a_pass_through: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    RobType == NoRoB |-> dut_rsp_valid == drv_rsp_valid && dut_rsp_ready == drv_rsp_ready
      && dut_rsp_data == drv_rsp_data && dut_rsp_id == drv_rsp_id
      && dut_rsp_last == drv_rsp_last
  ) else begin
    $display("%s %s: response did not pass through unchanged", mode_name, cur_test);
    count_error(cur_test);
  end

  // Slot tags are requested only by the reorder build
  a_rob_req: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) dut_rob_req == (RobType == NormalRoB)
  ) else flag_value(cur_test, RobType == NormalRoB, dut_rob_req);

  // Master, network ready and responder for one cycle
  task automatic drive_traffic(input int n_reqs, input bit stall);
    if (taken || !drv_ax_valid) begin
      drv_ax_len = LenWidth'($urandom_range(0, 7));
      drv_ax_id  = IdWidth'($urandom);
    end
    taken         = 1'b0;
    drv_ax_valid  = issued < n_reqs;
    drv_ax_ready  = !stall || $urandom_range(0, 3) != 0;
    drv_rsp_ready = !stall || $urandom_range(0, 1) != 0;
    // One beat at a time, any of the waiting ones
    if (pick < 0 && pend_q.size() != 0) begin
      pick = $urandom_range(0, pend_q.size() - 1);
    end
    drv_rsp_valid = pick >= 0;
    if (pick >= 0) begin
      {drv_rsp_data, drv_rsp_id, drv_rsp_idx, drv_rsp_last} = pend_q[pick];
    end
  endtask

  task automatic check_cycle(input string tname);
    int beats;
    bit room;
    bit fits;
    beats = int'(drv_ax_len) + 1;
    room  = drv_ax_valid && beats <= free_model;
    fits  = room && drv_ax_ready;
    taken = dut_ax_ready;
    a_room: assert (dut_ax_valid == room) else flag_value("capacity", room, dut_ax_valid);
    a_capacity: assert (dut_ax_ready == fits) else flag_value("capacity", fits, dut_ax_ready);
    if (dut_ax_ready) begin
      a_tail: assert (dut_rob_idx == IdxWidth'(tail_model))
        else flag_value(tname, tail_model, dut_rob_idx);
      for (int k = 0; k < beats; k++) begin
        pend_q.push_back({DataWidth'(issued * 16 + k), drv_ax_id,
                          IdxWidth'((int'(dut_rob_idx) + k) % RobSize), k == beats - 1});
        exp_q.push_back({DataWidth'(issued * 16 + k), drv_ax_id, k == beats - 1});
      end
      free_model -= beats;
      tail_model = (tail_model + beats) % RobSize;
      issued++;
    end
    if (drv_rsp_valid && dut_rsp_ready) begin
      pend_q.delete(pick);
      pick = -1;
    end
    if (dut_rsp_valid && drv_rsp_ready) begin
      if (exp_q.size() == 0) begin
        $display("%s %s: response beat with no request waiting for it", mode_name, tname);
        count_error(tname);
      end else begin
        a_order: assert ({dut_rsp_data, dut_rsp_id, dut_rsp_last} == exp_q[0])
          else flag_value(tname, exp_q[0], {dut_rsp_data, dut_rsp_id, dut_rsp_last});
        void'(exp_q.pop_front());
      end
      free_model++;
    end
  endtask

  task automatic run_traffic(input string tname, input int n_reqs, input bit stall);
    int cycles;
    cycles   = 0;
    issued   = 0;
    cur_test = tname;
    drive_traffic(n_reqs, stall);
    while ((issued < n_reqs || exp_q.size() != 0) && cycles < RunLimit) begin
      @(negedge clk_i);
      check_cycle(tname);
      @(posedge clk_i);
      #1;
      drive_traffic(n_reqs, stall);
      cycles++;
    end
    if (cycles >= RunLimit) begin
      $display("%s %s: timed out with %0d beats never delivered", mode_name, tname,
               exp_q.size());
      count_error(tname);
    end
    drv_ax_valid  = 1'b0;
    drv_rsp_valid = 1'b0;
    finish_test(tname);
  endtask

  task automatic offer_request(input string tname, input int id, input int dest, input bit accept);
    drv_ax_valid = 1'b1;
    drv_ax_id    = IdWidth'(id);
    drv_ax_dest  = DestWidth'(dest);
    @(negedge clk_i);
    a_gate: assert (dut_ax_valid == accept && dut_ax_ready == accept)
      else flag_value(tname, {accept, accept}, {dut_ax_valid, dut_ax_ready});
    @(posedge clk_i);
    #1;
    drv_ax_valid = 1'b0;
  endtask

  task automatic return_last(input string tname, input int id);
    drv_rsp_valid = 1'b1;
    drv_rsp_id    = IdWidth'(id);
    drv_rsp_data  = $urandom;
    drv_rsp_last  = 1'b1;
    @(negedge clk_i);
    a_through: assert (dut_rsp_valid && dut_rsp_data == drv_rsp_data)
      else flag_value(tname, drv_rsp_data, dut_rsp_data);
    @(posedge clk_i);
    #1;
    drv_rsp_valid = 1'b0;
  endtask

  initial begin : stimulus
    int cycles;
    mode_name     = RobType == NormalRoB ? "NormalRoB" : "NoRoB";
    cur_test      = "reset";
    done_o        = 1'b0;
    pass_cnt_o    = 0;
    fail_cnt_o    = 0;
    drv_ax_valid  = 1'b0;
    drv_ax_len    = '0;
    drv_ax_id     = '0;
    drv_ax_dest   = '0;
    drv_ax_ready  = 1'b0;
    drv_rsp_valid = 1'b0;
    drv_rsp_data  = '0;
    drv_rsp_id    = '0;
    drv_rsp_idx   = '0;
    drv_rsp_last  = 1'b0;
    drv_rsp_ready = 1'b0;
    free_model    = RobSize;
    tail_model    = 0;
    issued        = 0;
    pick          = -1;
    taken         = 1'b0;
    cycles        = 0;
    while (arst_n_i !== 1'b1 && cycles < 50) begin
      @(negedge clk_i);
      cycles++;
    end
    if (arst_n_i !== 1'b1) begin
      $display("%s reset: reset was never released", mode_name);
      count_error("reset");
    end
    a_reset_idle: assert (!dut_ax_valid && !dut_rsp_valid)
      else flag_value("reset", 0, {dut_ax_valid, dut_rsp_valid});
    finish_test("reset");
    @(posedge clk_i);
    #1;
    if (RobType == NormalRoB) begin
      run_traffic("order", 40, 1'b0);
      run_traffic("backpressure", 60, 1'b1);
      finish_test("capacity");
    end else begin
      drv_ax_ready  = 1'b1;
      drv_rsp_ready = 1'b1;
      cur_test      = "destination";
      // ID 3 is bound to destination 1 until its responses are back
      offer_request("destination", 3, 1, 1'b1);
      offer_request("destination", 3, 2, 1'b0);
      offer_request("destination", 3, 1, 1'b1);
      return_last("destination", 3);
      return_last("destination", 3);
      offer_request("destination", 3, 2, 1'b1);
      return_last("destination", 3);
      finish_test("destination");
      cur_test = "limit";
      for (int n = 0; n < MaxTxnsPerId; n++) begin
        offer_request("limit", 5, 0, 1'b1);
      end
      offer_request("limit", 5, 0, 1'b0);
      return_last("limit", 5);
      offer_request("limit", 5, 0, 1'b1);
      for (int n = 0; n < MaxTxnsPerId; n++) begin
        return_last("limit", 5);
      end
      finish_test("limit");
    end
    done_o = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb_rob_top.sv ====
// **********************************************************************
// Reorder wrapper testbench top
// Runs the reorder build and the no-reorder build side by side and
// sums their results
// **********************************************************************
`timescale 1ns/1ns
`default_nettype none

module tb_rob_top
  import rob_cfg_pkg::*;
();

  logic clk;
  logic arst_n;
  logic normal_done;
  logic no_rob_done;
  int   normal_pass;
  int   normal_fail;
  int   no_rob_pass;
  int   no_rob_fail;

  initial begin : clock_gen
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  tb_rob_harness #(
    .RobType      ( NormalRoB ),
    .RobSize      ( 16        ),
    .MaxTxnsPerId ( 4         )
  ) normal_harness (
    .clk_i      ( clk         ),
    .arst_n_i   ( arst_n      ),
    .done_o     ( normal_done ),
    .pass_cnt_o ( normal_pass ),
    .fail_cnt_o ( normal_fail )
  );

  tb_rob_harness #(
    .RobType      ( NoRoB ),
    .RobSize      ( 16    ),
    .MaxTxnsPerId ( 4     )
  ) no_rob_harness (
    .clk_i      ( clk         ),
    .arst_n_i   ( arst_n      ),
    .done_o     ( no_rob_done ),
    .pass_cnt_o ( no_rob_pass ),
    .fail_cnt_o ( no_rob_fail )
  );

  initial begin : run_ctrl
    int cycles;
    int passed;
    int failed;
    bit finished;
    void'($urandom(32'hd9e8_ad32));
    arst_n = 1'b0;
    repeat (3) begin
      @(posedge clk);
    end
    #1;
    arst_n = 1'b1;
    cycles = 0;
    while (!(normal_done && no_rob_done) && cycles < 20000) begin
      @(posedge clk);
      cycles++;
    end
    finished = normal_done && no_rob_done;
    if (!finished) begin
      $display("Harnesses still busy after %0d cycles", cycles);
    end
    passed = normal_pass + no_rob_pass;
    failed = normal_fail + no_rob_fail + (finished ? 0 : 1);
    $display("Tests passed: %0d, failed: %0d", passed, failed);
    if (failed == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
